/* src/conv_params_pkg.sv */
// ==============================
// Convolution engine size limits
// and parameter-memory layout
// ==============================
`default_nettype none

package conv_params_pkg;

    localparam int MAX_DIM    = 32;            // Largest input height or width
    localparam int MAX_K      = 3;             // Largest kernel size
    localparam int NUM_UNITS  = 4;             // Output channels in parallel
    localparam int TAPS_MAX   = MAX_K * MAX_K; // Weight slots per unit

    // Unit u owns words u*UNIT_SLOTS .. u*UNIT_SLOTS+9, bias last
    localparam int UNIT_SLOTS = TAPS_MAX + 1;
    localparam int BIAS_TAP   = TAPS_MAX;      // Tap index of the bias slot

endpackage

`default_nettype wire

/* src/conv_types_pkg.sv */
// ==============================
// Convolution engine types
// Vector widths and FSM phases
// ==============================
`default_nettype none

package conv_types_pkg;

    typedef logic        [7:0]  pix_t;      // Input pixel, unsigned
    typedef logic signed [7:0]  wgt_t;      // Weight or bias word
    typedef logic signed [19:0] acc_t;      // Full-precision sum
    typedef logic        [5:0]  dim_t;      // Dimension, count or stride
    typedef logic        [9:0]  in_addr_t;  // Input buffer address
    typedef logic        [5:0]  par_addr_t; // Parameter memory address
    typedef logic        [3:0]  tap_t;      // Tap 0..8, 9 is the bias
    typedef logic        [1:0]  ch_t;       // Output channel

    // Control phases
    typedef enum logic [2:0] {
        IDLE,
        DIVIDE,
        LOAD,
        COMPUTE,
        DRAIN,
        FINISH
    } ctrl_state_e;

endpackage

`default_nettype wire

/* src/stride_div.sv */
// ==============================
// Stride divider
// Restoring shift-subtract, one
// quotient bit per cycle
// ==============================
`timescale 1ns/1ps
`default_nettype none

module stride_div
    import conv_types_pkg::*;
(
    input  logic clk,
    input  logic rst,
    input  logic div_start,
    input  dim_t dividend,
    input  dim_t divisor,
    output dim_t quotient,
    output logic div_done
);

    localparam int W = $bits(dim_t);

    dim_t         rem_q;
    dim_t         quo_q;
    dim_t         dsr_q;
    logic [2:0]   step_cnt;
    logic         busy;
    logic [W:0]   shifted;
    logic [W+1:0] diff;
    logic         last_step;

    // Partial remainder with the next dividend bit shifted in
    assign shifted   = {rem_q, quo_q[W-1]};
    assign diff      = {1'b0, shifted} - {2'b00, dsr_q};
    assign last_step = busy && (step_cnt == 3'(W));

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            busy     <= 1'b0;
            step_cnt <= '0;
            div_done <= 1'b0;
        end else begin
            div_done <= 1'b0;
            if (div_start) begin
                busy     <= 1'b1;
                step_cnt <= '0;
            end else if (last_step) begin
                busy     <= 1'b0;
                div_done <= 1'b1;
            end else if (busy) begin
                step_cnt <= step_cnt + 3'd1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (div_start) begin
            rem_q <= '0;
            quo_q <= dividend;
            dsr_q <= divisor;
        end else if (busy && !last_step) begin
            if (diff[W+1]) begin            // Borrow, restore
                rem_q <= shifted[W-1:0];
                quo_q <= {quo_q[W-2:0], 1'b0};
            end else begin
                rem_q <= diff[W-1:0];
                quo_q <= {quo_q[W-2:0], 1'b1};
            end
        end
        if (last_step) quotient <= quo_q;
    end

endmodule

`default_nettype wire

/* src/conv_ctrl.sv */
// ==============================
// Convolution control
// Phase FSM, configuration,
// output size and weight loading
// ==============================
`timescale 1ns/1ps
`default_nettype none

module conv_ctrl
    import conv_params_pkg::*, conv_types_pkg::*;
(
    input  logic                 clk,
    input  logic                 rst,
    input  logic                 start_valid,
    output logic                 start_ready,
    input  dim_t                 cfg_k,
    input  dim_t                 cfg_h,
    input  dim_t                 cfg_w,
    input  dim_t                 cfg_stride,
    output logic                 par_rd,
    output par_addr_t            par_addr,
    input  wgt_t                 par_rdata,
    output logic [NUM_UNITS-1:0] ld_en,
    output tap_t                 ld_tap,
    output wgt_t                 ld_data,
    output logic                 compute_go,
    output dim_t                 k,
    output dim_t                 w,
    output dim_t                 stride,
    output dim_t                 out_h,
    output dim_t                 out_w,
    input  logic                 gen_done,
    input  logic                 pack_busy,
    output logic                 done
);

    ctrl_state_e state;
    logic        accept;
    logic        load_fin;
    logic        div_done_h;
    logic        div_done_w;
    dim_t        quot_h;
    dim_t        quot_w;
    tap_t        tap;
    tap_t        last_wtap;
    ch_t         unit;
    par_addr_t   unit_base;

    assign start_ready = (state == IDLE);
    assign accept      = start_valid && start_ready;
    assign par_rd      = (state == LOAD) && !load_fin;
    assign par_addr    = unit_base + par_addr_t'(tap);
    assign ld_data     = par_rdata;  // Already aligned with the delayed enable
    assign compute_go  = (state == LOAD) && load_fin;
    assign done        = (state == FINISH);

    // ==============================
    // Output size, (in - K) / S + 1
    // ==============================
    stride_div u_div_h (
        .clk       (clk),
        .rst       (rst),
        .div_start (accept),
        .dividend  (cfg_h - cfg_k),
        .divisor   (cfg_stride),
        .quotient  (quot_h),
        .div_done  (div_done_h)
    );

    stride_div u_div_w (
        .clk       (clk),
        .rst       (rst),
        .div_start (accept),
        .dividend  (cfg_w - cfg_k),
        .divisor   (cfg_stride),
        .quotient  (quot_w),
        .div_done  (div_done_w)
    );

    always_ff @(posedge clk) begin
        if (accept) begin
            k         <= cfg_k;
            w         <= cfg_w;
            stride    <= cfg_stride;
            last_wtap <= tap_t'(cfg_k * cfg_k - 1);
        end
        if (div_done_h) out_h <= quot_h + 6'd1;
        if (div_done_w) out_w <= quot_w + 6'd1;
        ld_tap <= tap;                 // Lines up with par_rdata
    end

    // ==============================
    // Phase FSM
    // ==============================
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state     <= IDLE;
            load_fin  <= 1'b0;
            ld_en     <= '0;
            tap       <= '0;
            unit      <= '0;
            unit_base <= '0;
        end else begin
            ld_en <= '0;
            case (state)
                IDLE: begin
                    if (accept) begin
                        state     <= DIVIDE;
                        tap       <= '0;
                        unit      <= '0;
                        unit_base <= '0;
                    end
                end
                DIVIDE: if (div_done_h && div_done_w) state <= LOAD;
                LOAD: begin
                    if (load_fin) begin        // Last bias lands this cycle
                        load_fin <= 1'b0;
                        state    <= COMPUTE;
                    end else begin
                        ld_en[unit] <= 1'b1;
                        if (tap == tap_t'(BIAS_TAP)) begin
                            tap       <= '0;
                            unit      <= unit + 2'd1;
                            unit_base <= unit_base + par_addr_t'(UNIT_SLOTS);
                            load_fin  <= (unit == ch_t'(NUM_UNITS - 1));
                        end else if (tap == last_wtap) begin
                            tap <= tap_t'(BIAS_TAP);  // Skip unused slots
                        end else begin
                            tap <= tap + 4'd1;
                        end
                    end
                end
                COMPUTE: if (gen_done) state <= DRAIN;
                DRAIN:   if (!pack_busy) state <= FINISH;
                FINISH:  state <= IDLE;
                default: state <= IDLE;
            endcase
        end
    end

endmodule

`default_nettype wire

/* src/window_addr_gen.sv */
// ==============================
// Window address walker
// Raster walk of KxK windows with
// tap markers and output stall
// ==============================
`timescale 1ns/1ps
`default_nettype none

module window_addr_gen
    import conv_params_pkg::*, conv_types_pkg::*;
(
    input  logic     clk,
    input  logic     rst,
    input  logic     compute_go,
    input  dim_t     k,
    input  dim_t     w,
    input  dim_t     stride,
    input  dim_t     out_h,
    input  dim_t     out_w,
    input  logic     pack_busy,
    output logic     in_rd,
    output in_addr_t in_addr,
    output logic     pix_valid,
    output logic     pix_first,
    output logic     pix_last,
    output tap_t     pix_tap,
    output logic     gen_done
);

    localparam int KW = $clog2(MAX_K + 1);

    logic [KW-1:0] kc;
    logic [KW-1:0] kr;
    logic [KW-1:0] k_last;
    tap_t          tap;
    dim_t          ox;
    dim_t          oy;
    dim_t          prep_cnt;
    in_addr_t      addr;
    in_addr_t      line;       // Start of current kernel row
    in_addr_t      win;        // Window origin
    in_addr_t      row_base;   // Origin of first window in the output row
    in_addr_t      row_step;   // stride * w
    in_addr_t      next_win;
    logic          prep;
    logic          active;
    logic          first_tap;
    logic          last_tap;
    logic          row_end;
    logic          last_win;
    logic          issue;

    assign k_last    = KW'(k - 6'd1);
    assign first_tap = (kc == '0) && (kr == '0);
    assign last_tap  = (kc == k_last) && (kr == k_last);
    assign row_end   = (ox == out_w - 6'd1);
    assign last_win  = row_end && (oy == out_h - 6'd1);
    assign issue     = active && !(last_tap && pack_busy); // Hold last tap
    assign next_win  = row_end ? row_base + row_step : win + in_addr_t'(stride);

    assign in_rd   = issue;
    assign in_addr = addr;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            prep      <= 1'b0;
            active    <= 1'b0;
            pix_valid <= 1'b0;
            pix_first <= 1'b0;
            pix_last  <= 1'b0;
            gen_done  <= 1'b0;
        end else begin
            // Markers follow in_rd by one cycle, like the read data
            pix_valid <= issue;
            pix_first <= issue && first_tap;
            pix_last  <= issue && last_tap;
            gen_done  <= issue && last_tap && last_win;
            if (compute_go) begin
                prep <= 1'b1;
            end else if (prep && prep_cnt == 6'd1) begin
                prep   <= 1'b0;
                active <= 1'b1;
            end
            if (issue && last_tap && last_win) active <= 1'b0;
        end
    end

    // ==============================
    // Counters and addresses
    // ==============================
    always_ff @(posedge clk) begin
        pix_tap <= tap;
        if (compute_go) begin
            prep_cnt <= stride;
            row_step <= '0;
            kc       <= '0;
            kr       <= '0;
            tap      <= '0;
            ox       <= '0;
            oy       <= '0;
            addr     <= '0;
            line     <= '0;
            win      <= '0;
            row_base <= '0;
        end else if (prep) begin
            // Row step built by adding w once per stride
            prep_cnt <= prep_cnt - 6'd1;
            row_step <= row_step + in_addr_t'(w);
        end else if (issue) begin
            if (last_tap) begin
                kc   <= '0;
                kr   <= '0;
                tap  <= '0;
                win  <= next_win;
                line <= next_win;
                addr <= next_win;
                if (row_end) begin
                    ox       <= '0;
                    oy       <= oy + 6'd1;
                    row_base <= next_win;
                end else begin
                    ox <= ox + 6'd1;
                end
            end else if (kc == k_last) begin   // Next kernel row
                kc   <= '0;
                kr   <= kr + 1'b1;
                tap  <= tap + 4'd1;
                line <= line + in_addr_t'(w);
                addr <= line + in_addr_t'(w);
            end else begin
                kc   <= kc + 1'b1;
                tap  <= tap + 4'd1;
                addr <= addr + 10'd1;
            end
        end
    end

endmodule

`default_nettype wire

/* src/mac_unit.sv */
// ==============================
// Multiply-accumulate unit
// One output channel, bias plus
// weighted window pixels
// ==============================
`timescale 1ns/1ps
`default_nettype none

module mac_unit
    import conv_params_pkg::*, conv_types_pkg::*;
(
    input  logic clk,
    input  logic rst,
    input  logic ld_en,
    input  tap_t ld_tap,
    input  wgt_t ld_data,
    input  logic pix_valid,
    input  logic pix_first,
    input  logic pix_last,
    input  tap_t pix_tap,
    input  pix_t pix_data,
    output acc_t result
);

    wgt_t               wts [TAPS_MAX];
    wgt_t               bias;
    acc_t               acc;
    acc_t               sum;
    logic signed [16:0] prod;

    // Pixel is unsigned, zero bit keeps it positive
    assign prod = wts[pix_tap] * $signed({1'b0, pix_data});
    assign sum  = (pix_first ? acc_t'(bias) : acc) + acc_t'(prod);

    always_ff @(posedge clk) begin
        if (ld_en) begin
            if (ld_tap == tap_t'(BIAS_TAP)) begin
                bias <= ld_data;
            end else begin
                wts[ld_tap] <= ld_data;
            end
        end
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            acc    <= '0;
            result <= '0;
        end else if (pix_valid) begin
            acc <= sum;
            if (pix_last) result <= sum;  // Held while next window runs
        end
    end

endmodule

`default_nettype wire

/* src/output_packer.sv */
// ==============================
// Output packer
// Holds four channel results and
// streams them under valid/ready
// ==============================
`timescale 1ns/1ps
`default_nettype none

module output_packer
    import conv_params_pkg::*, conv_types_pkg::*;
(
    input  logic clk,
    input  logic rst,
    input  logic pix_last,
    input  acc_t result0,
    input  acc_t result1,
    input  acc_t result2,
    input  acc_t result3,
    output logic out_valid,
    input  logic out_ready,
    output acc_t out_data,
    output ch_t  out_ch,
    output logic pack_busy
);

    acc_t hold [NUM_UNITS];
    logic load_q;    // Results settle one cycle after pix_last
    logic sending;
    ch_t  ch;

    assign out_valid = sending;
    assign out_data  = hold[ch];
    assign out_ch    = ch;
    assign pack_busy = pix_last || load_q || sending;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            load_q  <= 1'b0;
            sending <= 1'b0;
            ch      <= '0;
        end else begin
            load_q <= pix_last;
            if (load_q) begin
                sending <= 1'b1;
                ch      <= '0;
            end else if (sending && out_ready) begin
                if (ch == ch_t'(NUM_UNITS - 1)) sending <= 1'b0;
                ch <= ch + 2'd1;         // Wraps to channel 0
            end
        end
    end

    always_ff @(posedge clk) begin
        if (load_q) begin
            hold[0] <= result0;
            hold[1] <= result1;
            hold[2] <= result2;
            hold[3] <= result3;
        end
    end

endmodule

`default_nettype wire

/* src/conv_accel.sv */
// ==============================
// Convolution accelerator top
// Control, walker, four MAC units
// and output stream
// ==============================
`timescale 1ns/1ps
`default_nettype none

module conv_accel
    import conv_params_pkg::*, conv_types_pkg::*;
(
    input  logic      clk,
    input  logic      rst,
    input  logic      start_valid,
    output logic      start_ready,
    input  dim_t      cfg_k,
    input  dim_t      cfg_h,
    input  dim_t      cfg_w,
    input  dim_t      cfg_stride,
    output logic      par_rd,
    output par_addr_t par_addr,
    input  wgt_t      par_rdata,
    output logic      in_rd,
    output in_addr_t  in_addr,
    input  pix_t      in_rdata,
    output logic      out_valid,
    input  logic      out_ready,
    output acc_t      out_data,
    output ch_t       out_ch,
    output logic      done
);

    logic [NUM_UNITS-1:0] ld_en;
    tap_t                 ld_tap;
    wgt_t                 ld_data;
    logic                 compute_go;
    dim_t                 k;
    dim_t                 w;
    dim_t                 stride;
    dim_t                 out_h;
    dim_t                 out_w;
    logic                 gen_done;
    logic                 pack_busy;
    logic                 pix_valid;
    logic                 pix_first;
    logic                 pix_last;
    tap_t                 pix_tap;
    acc_t                 result [NUM_UNITS];

    conv_ctrl u_ctrl (
        .clk         (clk),
        .rst         (rst),
        .start_valid (start_valid),
        .start_ready (start_ready),
        .cfg_k       (cfg_k),
        .cfg_h       (cfg_h),
        .cfg_w       (cfg_w),
        .cfg_stride  (cfg_stride),
        .par_rd      (par_rd),
        .par_addr    (par_addr),
        .par_rdata   (par_rdata),
        .ld_en       (ld_en),
        .ld_tap      (ld_tap),
        .ld_data     (ld_data),
        .compute_go  (compute_go),
        .k           (k),
        .w           (w),
        .stride      (stride),
        .out_h       (out_h),
        .out_w       (out_w),
        .gen_done    (gen_done),
        .pack_busy   (pack_busy),
        .done        (done)
    );

    window_addr_gen u_walker (
        .clk        (clk),
        .rst        (rst),
        .compute_go (compute_go),
        .k          (k),
        .w          (w),
        .stride     (stride),
        .out_h      (out_h),
        .out_w      (out_w),
        .pack_busy  (pack_busy),
        .in_rd      (in_rd),
        .in_addr    (in_addr),
        .pix_valid  (pix_valid),
        .pix_first  (pix_first),
        .pix_last   (pix_last),
        .pix_tap    (pix_tap),
        .gen_done   (gen_done)
    );

    // One unit per output channel, all see the same pixel
    for (genvar g = 0; g < NUM_UNITS; g++) begin : g_mac
        mac_unit u_mac (
            .clk       (clk),
            .rst       (rst),
            .ld_en     (ld_en[g]),
            .ld_tap    (ld_tap),
            .ld_data   (ld_data),
            .pix_valid (pix_valid),
            .pix_first (pix_first),
            .pix_last  (pix_last),
            .pix_tap   (pix_tap),
            .pix_data  (in_rdata),
            .result    (result[g])
        );
    end

    output_packer u_packer (
        .clk       (clk),
        .rst       (rst),
        .pix_last  (pix_last),
        .result0   (result[0]),
        .result1   (result[1]),
        .result2   (result[2]),
        .result3   (result[3]),
        .out_valid (out_valid),
        .out_ready (out_ready),
        .out_data  (out_data),
        .out_ch    (out_ch),
        .pack_busy (pack_busy)
    );

endmodule

`default_nettype wire

/* dv/conv_accel_asserts.sv */
// ==============================
// Convolution engine assertions
// Stream hold, done pulse, busy
// ==============================
`timescale 1ns/1ps
`default_nettype none

module conv_accel_asserts
    import conv_types_pkg::*;
(
    input logic clk,
    input logic rst,
    input logic start_valid,
    input logic start_ready,
    input logic par_rd,
    input logic in_rd,
    input logic out_valid,
    input logic out_ready,
    input acc_t out_data,
    input ch_t  out_ch,
    input logic done
);

    logic busy;        // From start acceptance to done
    logic par_rd_q;
    logic computing;   // From end of weight load to done

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            busy      <= 1'b0;
            par_rd_q  <= 1'b0;
            computing <= 1'b0;
        end else begin
            par_rd_q <= par_rd;
            if (start_valid && start_ready) begin
                busy <= 1'b1;
            end else if (done) begin
                busy <= 1'b0;
            end
            if (par_rd_q && !par_rd) begin   // Weight load just ended
                computing <= 1'b1;
            end else if (done) begin
                computing <= 1'b0;
            end
        end
    end

    a_hold: assert property (@(posedge clk) disable iff (rst)
        out_valid && !out_ready |=> out_valid && $stable(out_data) && $stable(out_ch))
        else $error("output changed while stalled");

    a_done: assert property (@(posedge clk) disable iff (rst) done |=> !done)
        else $error("done longer than one cycle");

    a_ready: assert property (@(posedge clk) disable iff (rst) busy |-> !start_ready)
        else $error("start_ready high during a run");

    a_rd: assert property (@(posedge clk) disable iff (rst) in_rd |-> computing)
        else $error("input read outside the compute phase");

endmodule

`default_nettype wire

/* dv/tb_conv_accel.sv */
// ==============================
// Convolution engine testbench
// Memory models, golden-file
// stimulus and stream checks
// ==============================
`timescale 1ns/1ps
`default_nettype none

module tb_conv_accel
    import conv_params_pkg::*, conv_types_pkg::*;
();

    logic      clk;
    logic      rst         = 1'b1;
    logic      start_valid = 1'b0;
    logic      start_ready;
    dim_t      cfg_k       = '0;
    dim_t      cfg_h       = '0;
    dim_t      cfg_w       = '0;
    dim_t      cfg_stride  = '0;
    logic      par_rd;
    par_addr_t par_addr;
    wgt_t      par_rdata   = '0;
    logic      in_rd;
    in_addr_t  in_addr;
    pix_t      in_rdata    = '0;
    logic      out_valid;
    logic      out_ready   = 1'b0;
    acc_t      out_data;
    ch_t       out_ch;
    logic      done;

    wgt_t      par_mem [64];
    pix_t      in_mem [1024];
    acc_t      exp_val [$];
    ch_t       exp_ch [$];
    logic      par_rd_q   = 1'b0;
    logic      in_rd_q    = 1'b0;
    par_addr_t par_addr_q = '0;
    in_addr_t  in_addr_q  = '0;
    logic      rand_ready = 1'b0;
    int        cycles     = 0;
    int        budget     = 200;   // Reset and gaps between cases
    int        done_count = 0;
    int        case_count = 0;

    conv_accel u_conv_accel (.*);

    bind conv_accel conv_accel_asserts u_asserts (
        .clk         (clk),
        .rst         (rst),
        .start_valid (start_valid),
        .start_ready (start_ready),
        .par_rd      (par_rd),
        .in_rd       (in_rd),
        .out_valid   (out_valid),
        .out_ready   (out_ready),
        .out_data    (out_data),
        .out_ch      (out_ch),
        .done        (done)
    );

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    // ==============================
    // Reporting and compare tasks
    // ==============================
    task automatic stop_on_error(input string msg);
        $display("%s", msg);
        $display("TEST FAILED");
        $fatal(1, "run stopped at first error");
    endtask

    task automatic check_acc(input string name, input acc_t got, input acc_t exp);
        if (got !== exp)
            stop_on_error($sformatf("mismatch %s got 0x%05h expected 0x%05h", name, got, exp));
    endtask

    task automatic check_ch(input string name, input ch_t got, input ch_t exp);
        if (got !== exp)
            stop_on_error($sformatf("mismatch %s got 0x%01h expected 0x%01h", name, got, exp));
    endtask

    task automatic check_bit(input string name, input logic got, input logic exp);
        if (got !== exp)
            stop_on_error($sformatf("mismatch %s got 0x%01h expected 0x%01h", name, got, exp));
    endtask

    // Watchdog budget grows as cases are loaded
    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles > budget) stop_on_error("watchdog expired before the run completed");
    end

    // ==============================
    // Memory models with one-cycle read
    // ==============================
    always @(posedge clk) begin
        par_rd_q   <= par_rd;
        par_addr_q <= par_addr;
        in_rd_q    <= in_rd;
        in_addr_q  <= in_addr;
    end

    always @(negedge clk) begin
        if (par_rd_q) par_rdata <= par_mem[par_addr_q];
        if (in_rd_q)  in_rdata  <= in_mem[in_addr_q];
        out_ready <= rand_ready ? 1'($urandom % 2) : 1'b1;
    end

    // Stream monitor
    always @(posedge clk) begin
        if (!rst) begin
            if (out_valid && out_ready) begin
                if (exp_val.size() == 0) begin
                    stop_on_error("output transfer beyond the expected stream");
                end else begin
                    check_ch("out_ch", out_ch, exp_ch.pop_front());
                    check_acc("out_data", out_data, exp_val.pop_front());
                end
            end
            if (done) begin
                if (exp_val.size() != 0) stop_on_error("done pulsed before the last output");
                done_count <= done_count + 1;
            end
        end
    end

    task automatic run_case(input int k, input int h, input int w, input int s, input int rnd);
        int oh;
        int ow;
        int load;
        oh   = (h - k) / s + 1;
        ow   = (w - k) / s + 1;
        load = NUM_UNITS * (k * k + 1) + 1;
        if (exp_val.size() != oh * ow * NUM_UNITS)
            stop_on_error("golden stream length does not follow the output size rule");
        budget     = budget + 4 * (load + oh * ow * (k * k + 4));
        rand_ready = (rnd != 0);
        @(negedge clk);
        start_valid = 1'b1;
        cfg_k       = dim_t'(k);
        cfg_h       = dim_t'(h);
        cfg_w       = dim_t'(w);
        cfg_stride  = dim_t'(s);
        @(posedge clk);
        while (!start_ready) @(posedge clk);
        @(negedge clk);
        start_valid = 1'b0;
        case_count++;
        while (done_count < case_count) @(posedge clk);
        @(negedge clk);
        check_bit("out_valid", out_valid, 1'b0);
        check_bit("start_ready", start_ready, 1'b1);
    endtask

    // ==============================
    // Golden-file driven sequence
    // ==============================
    initial begin
        int               fd;
        int               val;
        int               p_ptr;
        int               i_ptr;
        int               ck;
        int               ch;
        int               cw;
        int               cs;
        int               crnd;
        logic [7:0]       tag;
        logic [8*200-1:0] line_buf;
        void'($urandom(76));
        p_ptr = 0;
        i_ptr = 0;
        ck    = 1;
        ch    = 1;
        cw    = 1;
        cs    = 1;
        crnd  = 0;
        repeat (3) @(posedge clk);
        @(negedge clk);
        rst = 1'b0;
        @(negedge clk);
        check_bit("start_ready", start_ready, 1'b1);
        check_bit("out_valid", out_valid, 1'b0);
        check_bit("done", done, 1'b0);
        check_bit("par_rd", par_rd, 1'b0);
        check_bit("in_rd", in_rd, 1'b0);
        fd = $fopen("dv/conv_golden.txt", "r");
        if (fd == 0) stop_on_error("cannot open the golden file");
        while ($fscanf(fd, " %c", tag) == 1) begin
            case (tag)
                "#": void'($fgets(line_buf, fd));
                "C": begin
                    void'($fscanf(fd, "%d %d %d %d %d", ck, ch, cw, cs, crnd));
                    p_ptr = 0;
                    i_ptr = 0;
                    for (int a = 0; a < 1024; a++)
                        in_mem[a] = pix_t'(a * 7 + (a >> 8));  // Background
                end
                "P": begin
                    for (int n = 0; n < UNIT_SLOTS; n++) begin
                        void'($fscanf(fd, "%d", val));
                        par_mem[p_ptr] = wgt_t'(val);
                        p_ptr++;
                    end
                end
                "I": begin
                    for (int n = 0; n < cw; n++) begin
                        void'($fscanf(fd, "%d", val));
                        in_mem[i_ptr] = pix_t'(val);
                        i_ptr++;
                    end
                end
                "E": begin
                    for (int c = 0; c < NUM_UNITS; c++) begin
                        void'($fscanf(fd, "%d", val));
                        exp_ch.push_back(ch_t'(c));
                        exp_val.push_back(acc_t'(val));
                    end
                end
                "R": run_case(ck, ch, cw, cs, crnd);
                default: stop_on_error("unknown line tag in the golden file");
            endcase
        end
        $fclose(fd);
        if (case_count == 3 && done_count == case_count && exp_val.size() == 0) begin
            $display("TEST PASSED");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* dv/conv_golden.txt */
# C k h w stride rand_ready, P ten words of one unit (9 weights then bias)
# I one input row, E channel 0..3 values of one output pixel, R runs the case
# Case A, 3x3 kernel, stride 2, 5x5 input
C 3 5 5 2 0
P 1 1 1 1 1 1 1 1 1 0
P 0 0 0 0 -1 0 0 0 0 7
P 1 0 -1 2 0 -2 1 0 -1 -3
P 1 2 1 0 0 0 -1 -2 -1 100
I 0 1 2 3 4
I 10 11 12 13 14
I 20 21 22 23 24
I 30 31 32 33 34
I 40 41 42 43 44
E 99 -4 -11 20
E 117 -6 -11 20
E 279 -24 -11 20
E 297 -26 -11 20
R
# Case B, 2x2 kernel, stride 1, 4x5 input, random back-pressure
C 2 4 5 1 1
P 1 1 1 1 0 0 0 0 0 0
P 2 0 0 -1 0 0 0 0 0 10
P 0 3 -1 0 0 0 0 0 0 -5
P 127 127 127 127 0 0 0 0 0 -128
I 0 1 2 3 4
I 1 2 3 4 5
I 2 3 4 5 6
I 3 4 5 6 7
E 4 8 -3 380
E 8 9 -1 888
E 12 10 1 1396
E 16 11 3 1904
E 8 9 -1 888
E 12 10 1 1396
E 16 11 3 1904
E 20 12 5 2412
E 12 10 1 1396
E 16 11 3 1904
E 20 12 5 2412
E 24 13 7 2920
R
# Case C, 1x1 kernel, stride 3, 7x7 input
C 1 7 7 3 0
P 1 0 0 0 0 0 0 0 0 0
P -2 0 0 0 0 0 0 0 0 5
P 3 0 0 0 0 0 0 0 0 -10
P 100 0 0 0 0 0 0 0 0 -1
I 0 1 2 3 4 5 6
I 7 8 9 10 11 12 13
I 14 15 16 17 18 19 20
I 21 22 23 24 25 26 27
I 28 29 30 31 32 33 34
I 35 36 37 38 39 40 41
I 42 43 44 45 46 47 48
E 0 5 -10 -1
E 3 -1 -1 299
E 6 -7 8 599
E 21 -37 53 2099
E 24 -43 62 2399
E 27 -49 71 2699
E 42 -79 116 4199
E 45 -85 125 4499
E 48 -91 134 4799
R

/* conv_accel.f */
src/conv_params_pkg.sv
src/conv_types_pkg.sv
src/stride_div.sv
src/conv_ctrl.sv
src/window_addr_gen.sv
src/mac_unit.sv
src/output_packer.sv
src/conv_accel.sv
dv/conv_accel_asserts.sv
dv/tb_conv_accel.sv

/* Makefile */
.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator and run the testbench"
	@echo "  clean  remove the build directory"
	@echo "  help   show this list"

test:
	verilator --binary --timing --assert --top-module tb_conv_accel \
		-f conv_accel.f -o Vtb_conv_accel
	./obj_dir/Vtb_conv_accel | tee /dev/stderr | grep -q "TEST PASSED"

clean:
	rm -rf obj_dir
